/* hw/i2c_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c bus controller shared definitions
// command codes, pad pair and filtered bus view, width defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package i2c_pkg;

    // default prescale width, top level may override
    localparam int unsigned PRESCALE_W   = 16;

    // prescale >> 2 gives the sample tick, 16x bus rate
    localparam int unsigned FILTER_SHIFT = 2;

    // bit level commands from the byte controller
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,   // idle, nothing to do
        CMD_START = 3'd1,   // start or repeated start
        CMD_STOP  = 3'd2,   // stop condition
        CMD_WRITE = 3'd3,   // drive one data bit
        CMD_READ  = 3'd4,   // release sda, sample one bit
        CMD_WAIT  = 3'd5    // four phases, both lines released
    } i2c_cmd_e;

    // one bit per bus line
    // raw pad level on input, active low enable on output
    typedef struct packed {
        logic scl;
        logic sda;
    } line_pair_t;

    // filtered line state as seen by clock gen and sequencer
    typedef struct packed {
        logic scl;      // filtered scl
        logic sda;      // filtered sda
        logic scl_d;    // scl one cycle back
        logic sda_d;    // sda one cycle back
        logic start;    // start condition seen, 1 cycle
        logic stop;     // stop condition seen, 1 cycle
    } bus_view_t;

endpackage

`default_nettype wire

/* hw/i2c_bit_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c bit clock
// prescale down counter giving the phase enable of the sequencer,
// frozen by slave clock stretching, restarted on clock sync
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_bit_clock #(
    parameter int unsigned PRESCALE_W = 16
) (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  ena_i,       // core enable
    input  wire logic                  sw_rst_i,    // abort transfer
    input  wire logic [PRESCALE_W-1:0] clk_cnt_i,   // prescale value
    input  wire logic                  scl_oen_i,   // our scl enable, active low
    input  wire i2c_pkg::bus_view_t    bus_i,       // filtered lines
    output      logic                  clk_en_o     // phase enable, 1 cycle
);

    logic                  scl_oen_q;   // scl enable one cycle back
    logic                  slave_wait_q;
    logic                  scl_sync;
    logic [PRESCALE_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            scl_oen_q <= 1'b1;      // released
        else
            scl_oen_q <= scl_oen_i;
    end

    // we just released scl but it stays low: slave is stretching
    // hold until the line really goes high
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            slave_wait_q <= 1'b0;
        else if (sw_rst_i)
            slave_wait_q <= 1'b0;
        else
            slave_wait_q <= (scl_oen_i & ~scl_oen_q & ~bus_i.scl) |
                            (slave_wait_q & ~bus_i.scl);
    end

    // scl released by us but pulled low by another master
    assign scl_sync = bus_i.scl_d & ~bus_i.scl & scl_oen_i;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cnt_q    <= '0;
            clk_en_o <= 1'b1;
        end
        else if (sw_rst_i)
        begin
            cnt_q    <= '0;
            clk_en_o <= 1'b1;
        end
        else if ((cnt_q == '0) || !ena_i || scl_sync)
        begin
            cnt_q    <= clk_cnt_i;      // reload, start low period on sync
            clk_en_o <= 1'b1;
        end
        else if (slave_wait_q)
        begin
            clk_en_o <= 1'b0;           // frozen while stretched
        end
        else
        begin
            cnt_q    <= cnt_q - PRESCALE_W'(1);
            clk_en_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/i2c_line_filter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c line filter and bus monitor
// syncs and majority filters scl/sda, flags start and stop,
// tracks bus busy and captures sda on the scl rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_line_filter #(
    parameter int unsigned PRESCALE_W = 16
) (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  ena_i,       // core enable
    input  wire logic                  sw_rst_i,    // abort transfer
    input  wire logic [PRESCALE_W-1:0] clk_cnt_i,   // prescale value
    input  wire i2c_pkg::line_pair_t   lines_i,     // raw pads, async
    output      i2c_pkg::bus_view_t    bus_o,       // filtered view
    output      logic                  busy_o,      // start seen, no stop yet
    output      logic                  dout_o       // last sampled read bit
);

    // sample counter drops the low prescale bits
    localparam int unsigned FCNT_W = PRESCALE_W - i2c_pkg::FILTER_SHIFT;

    // idle bus, both lines high, no events
    localparam i2c_pkg::bus_view_t BUS_IDLE = '{
        scl:   1'b1,
        sda:   1'b1,
        scl_d: 1'b1,
        sda_d: 1'b1,
        start: 1'b0,
        stop:  1'b0
    };

    i2c_pkg::line_pair_t sync1_q;       // first sync stage
    i2c_pkg::line_pair_t sync2_q;       // second sync stage, safe to use
    logic [FCNT_W-1:0]   filt_cnt_q;
    logic                sample_tick;
    logic [2:0]          scl_hist_q;    // last three scl samples
    logic [2:0]          sda_hist_q;    // last three sda samples
    i2c_pkg::bus_view_t  bus_q;

    function automatic logic maj3(input logic [2:0] h);
        return (h[2] & h[1]) | (h[1] & h[0]) | (h[2] & h[0]);
    endfunction

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            sync1_q <= '1;      // lines idle high
            sync2_q <= '1;
        end
        else if (sw_rst_i)
        begin
            sync1_q <= '1;
            sync2_q <= '1;
        end
        else
        begin
            sync1_q <= lines_i;
            sync2_q <= sync1_q;
        end
    end

    // sample tick every clk_cnt/4 cycles, i.e. 16 per bit
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            filt_cnt_q <= '0;
        else if (!ena_i || sw_rst_i)
            filt_cnt_q <= '0;
        else if (sample_tick)
            filt_cnt_q <= clk_cnt_i[PRESCALE_W-1:i2c_pkg::FILTER_SHIFT];
        else
            filt_cnt_q <= filt_cnt_q - FCNT_W'(1);
    end

    assign sample_tick = (filt_cnt_q == '0);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            scl_hist_q <= 3'b111;
            sda_hist_q <= 3'b111;
        end
        else if (sw_rst_i)
        begin
            scl_hist_q <= 3'b111;
            sda_hist_q <= 3'b111;
        end
        else if (sample_tick)
        begin
            scl_hist_q <= {scl_hist_q[1:0], sync2_q.scl};
            sda_hist_q <= {sda_hist_q[1:0], sync2_q.sda};
        end
    end

    // vote, delay, and edge based start/stop in one stage
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            bus_q <= BUS_IDLE;
        else if (sw_rst_i)
            bus_q <= BUS_IDLE;
        else
        begin
            bus_q.scl   <= maj3(scl_hist_q);
            bus_q.sda   <= maj3(sda_hist_q);
            bus_q.scl_d <= bus_q.scl;
            bus_q.sda_d <= bus_q.sda;
            bus_q.start <= ~bus_q.sda &  bus_q.sda_d & bus_q.scl;  // sda falls, scl high
            bus_q.stop  <=  bus_q.sda & ~bus_q.sda_d & bus_q.scl;  // sda rises, scl high
        end
    end

    assign bus_o = bus_q;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            busy_o <= 1'b0;
        else if (sw_rst_i)
            busy_o <= 1'b0;
        else
            busy_o <= (bus_q.start | busy_o) & ~bus_q.stop;
    end

    // read bit, taken when scl goes high
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            dout_o <= 1'b1;
        else if (sw_rst_i)
            dout_o <= 1'b1;
        else if (bus_q.scl & ~bus_q.scl_d)
            dout_o <= bus_q.sda;
    end

endmodule

`default_nettype wire

/* hw/i2c_bit_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c bit sequencer
// runs each command as four clocked phases, drives the open drain
// enables of scl and sda and detects loss of arbitration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_bit_sequencer (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                sw_rst_i,      // abort transfer
    input  wire i2c_pkg::i2c_cmd_e   cmd_i,         // bit command
    input  wire logic                cmd_valid_i,   // looked at only when idle
    input  wire logic                din_i,         // bit to write
    input  wire logic                clk_en_i,      // phase enable
    input  wire i2c_pkg::bus_view_t  bus_i,         // filtered lines
    output      logic                cmd_ack_o,     // command done, 1 cycle
    output      logic                al_o,          // arbitration lost
    output      i2c_pkg::line_pair_t lines_oen_o    // active low enables
);

    i2c_pkg::i2c_cmd_e   cmd_q;         // running command, NONE = idle
    logic [1:0]          phase_q;       // phase 0..3 of the command
    logic                cmd_stop_q;    // last accepted command was STOP
    logic                sda_chk_q;     // compare sda against our drive
    i2c_pkg::line_pair_t oen_q;
    i2c_pkg::line_pair_t oen_nxt;
    logic                sda_chk_nxt;
    logic                idle;

    assign idle = (cmd_q == i2c_pkg::CMD_NONE);

    // line enables per command and phase, 1 = released
    always_comb
    begin
        oen_nxt     = oen_q;        // idle keeps the lines as they are
        sda_chk_nxt = 1'b0;
        case (cmd_q)
            i2c_pkg::CMD_START:
            begin
                case (phase_q)
                    2'd0:    oen_nxt = '{scl: oen_q.scl, sda: 1'b1};   // sda up first
                    2'd1:    oen_nxt = '{scl: 1'b1, sda: 1'b1};        // scl up
                    2'd2:    oen_nxt = '{scl: 1'b1, sda: 1'b0};        // sda down, start
                    default: oen_nxt = '{scl: 1'b0, sda: 1'b0};        // scl down
                endcase
            end
            i2c_pkg::CMD_STOP:
            begin
                case (phase_q)
                    2'd0:    oen_nxt = '{scl: 1'b0, sda: 1'b0};
                    2'd1:    oen_nxt = '{scl: 1'b1, sda: 1'b0};        // scl up
                    2'd2:    oen_nxt = '{scl: 1'b1, sda: 1'b0};
                    default: oen_nxt = '{scl: 1'b1, sda: 1'b1};        // sda up, stop
                endcase
            end
            i2c_pkg::CMD_READ:
            begin
                case (phase_q)
                    2'd0:    oen_nxt = '{scl: 1'b0, sda: 1'b1};        // sda to slave
                    2'd1:    oen_nxt = '{scl: 1'b1, sda: 1'b1};
                    2'd2:    oen_nxt = '{scl: 1'b1, sda: 1'b1};
                    default: oen_nxt = '{scl: 1'b0, sda: 1'b1};
                endcase
            end
            i2c_pkg::CMD_WRITE:
            begin
                oen_nxt.sda = din_i;        // data held all four phases
                oen_nxt.scl = (phase_q == 2'd1) || (phase_q == 2'd2);
                sda_chk_nxt = (phase_q == 2'd2);    // scl high and settled
            end
            i2c_pkg::CMD_WAIT:
            begin
                oen_nxt = '{scl: 1'b1, sda: 1'b1};
            end
            default:
            begin
                oen_nxt = oen_q;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cmd_q     <= i2c_pkg::CMD_NONE;
            phase_q   <= 2'd0;
            cmd_ack_o <= 1'b0;
            oen_q     <= '1;
            sda_chk_q <= 1'b0;
        end
        else if (al_o || sw_rst_i)
        begin
            cmd_q     <= i2c_pkg::CMD_NONE;     // drop everything, free the bus
            phase_q   <= 2'd0;
            cmd_ack_o <= 1'b0;
            oen_q     <= '1;
            sda_chk_q <= 1'b0;
        end
        else
        begin
            cmd_ack_o <= 1'b0;
            oen_q     <= oen_nxt;
            sda_chk_q <= sda_chk_nxt;
            if (idle)
            begin
                phase_q <= 2'd0;
                if (cmd_valid_i)
                begin
                    case (cmd_i)
                        i2c_pkg::CMD_START,
                        i2c_pkg::CMD_STOP,
                        i2c_pkg::CMD_WRITE,
                        i2c_pkg::CMD_READ,
                        i2c_pkg::CMD_WAIT: cmd_q <= cmd_i;
                        default:           cmd_q <= i2c_pkg::CMD_NONE;
                    endcase
                end
            end
            else if (clk_en_i)
            begin
                phase_q <= phase_q + 2'd1;      // wraps to 0 after the last phase
                if (phase_q == 2'd3)
                begin
                    cmd_q     <= i2c_pkg::CMD_NONE;
                    cmd_ack_o <= 1'b1;
                end
            end
        end
    end

    // remember whether a stop was asked for
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            cmd_stop_q <= 1'b0;
        else if (sw_rst_i)
            cmd_stop_q <= 1'b0;
        else if (idle && cmd_valid_i)
            cmd_stop_q <= (cmd_i == i2c_pkg::CMD_STOP);
    end

    // lost: sda released but low, or a stop we did not ask for
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            al_o <= 1'b0;
        else if (sw_rst_i)
            al_o <= 1'b0;
        else
            al_o <= (sda_chk_q & ~bus_i.sda & oen_q.sda) |
                    (~idle & bus_i.stop & ~cmd_stop_q);
    end

    assign lines_oen_o = oen_q;

endmodule

`default_nettype wire

/* hw/i2c_bus_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c master bit level bus controller
// line filter, bit clock and bit sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl #(
    parameter int unsigned PRESCALE_W = i2c_pkg::PRESCALE_W
) (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  ena_i,       // core enable
    input  wire logic                  sw_rst_i,    // abort transfer, clear flags
    input  wire logic [PRESCALE_W-1:0] clk_cnt_i,   // prescale, phase = value + 1
    input  wire i2c_pkg::i2c_cmd_e     cmd_i,
    input  wire logic                  cmd_valid_i,
    input  wire logic                  din_i,
    input  wire i2c_pkg::line_pair_t   lines_i,     // raw scl/sda pads
    output      logic                  cmd_ack_o,
    output      logic                  busy_o,
    output      logic                  al_o,
    output      logic                  dout_o,
    output      i2c_pkg::line_pair_t   lines_oen_o  // pad enables, pads tied low
);

    i2c_pkg::bus_view_t bus;        // filtered bus state
    logic               clk_en;     // phase enable

    i2c_line_filter #(
        .PRESCALE_W (PRESCALE_W)
    ) i_filter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ena_i     (ena_i),
        .sw_rst_i  (sw_rst_i),
        .clk_cnt_i (clk_cnt_i),
        .lines_i   (lines_i),
        .bus_o     (bus),
        .busy_o    (busy_o),
        .dout_o    (dout_o)
    );

    i2c_bit_clock #(
        .PRESCALE_W (PRESCALE_W)
    ) i_clock (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ena_i     (ena_i),
        .sw_rst_i  (sw_rst_i),
        .clk_cnt_i (clk_cnt_i),
        .scl_oen_i (lines_oen_o.scl),   // for stretch and sync detection
        .bus_i     (bus),
        .clk_en_o  (clk_en)
    );

    i2c_bit_sequencer i_seq (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .sw_rst_i    (sw_rst_i),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .din_i       (din_i),
        .clk_en_i    (clk_en),
        .bus_i       (bus),
        .cmd_ack_o   (cmd_ack_o),
        .al_o        (al_o),
        .lines_oen_o (lines_oen_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset generator
// free running clock, active low reset held for a few cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 4,
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;                      // in reset from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/i2c_bus_ctrl_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c bus controller port checker
// concurrent assertions on ack, arbitration loss and line enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl_chk (
    input wire logic       clk_i,
    input wire logic       rstn_i,
    input wire logic       cmd_ack_i,     // dut cmd_ack_o
    input wire logic       al_i,          // dut al_o
    input wire logic [1:0] lines_oen_i    // dut enables, scl then sda
);

    // ack is a single cycle pulse
    ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_ack_i |=> !cmd_ack_i)
        else $error("cmd_ack_o high for two cycles in a row");

    // lost arbitration frees both lines
    al_release: assert property (@(posedge clk_i) disable iff (!rstn_i)
        al_i |=> (lines_oen_i == 2'b11))
        else $error("lines not released after al_o");

    // a lost command never completes
    ack_al_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(cmd_ack_i && al_i))
        else $error("cmd_ack_o and al_o high together");

endmodule

`default_nettype wire

/* testbench/i2c_bus_ctrl_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c bus controller testbench
// command table against a wired-and bus with a simple slave model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl_tb;

    localparam int CLK_CNT     = 15;    // phase = 16 cycles
    localparam int NROWS       = 10;
    localparam int STRETCH_CYC = 80;    // slave holds scl this long
    localparam int FILTER_CYC  = 12;    // pad to bus view, worst case
    localparam int SETTLE_CYC  = 32;
    localparam int ROW_CYC     = 4 * (CLK_CNT + 1) + STRETCH_CYC + 4 * FILTER_CYC + SETTLE_CYC + 4;
    localparam int TIMEOUT_NS  = (8 + NROWS * ROW_CYC) * 4;

    localparam logic [1:0] SLV_NONE    = 2'd0;
    localparam logic [1:0] SLV_STRETCH = 2'd1;   // hold scl low
    localparam logic [1:0] SLV_SDA_LOW = 2'd2;   // pull sda low

    typedef struct packed {
        i2c_pkg::i2c_cmd_e cmd;
        logic              din;
        logic [1:0]        slave;
        logic              exp_ack;
        logic              exp_al;
        logic              chk_data;     // compare dout and sampled sda
        logic              exp_data;
        logic              exp_busy;     // after settling
        logic [1:0]        exp_lines;    // scl, sda after settling
    } row_t;

    logic                clk;
    logic                rstn;
    logic                ena;
    logic                sw_rst;
    logic [15:0]         clk_cnt;
    i2c_pkg::i2c_cmd_e   cmd;
    logic                cmd_valid;
    logic                din;
    i2c_pkg::line_pair_t lines;         // wired-and bus
    i2c_pkg::line_pair_t lines_oen;
    logic                cmd_ack;
    logic                busy;
    logic                al;
    logic                dout;
    logic                slave_scl_low;
    logic                slave_sda_low;
    logic                scl_prev;
    logic                sampled_sda;   // sda at last raw scl rise
    int                  errors;
    int                  base_cycles;
    row_t                rows [NROWS];

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(8)) i_clk (.clk_o(clk), .rstn_o(rstn));

    i2c_bus_ctrl #(.PRESCALE_W(16)) i_dut (
        .clk_i(clk), .rstn_i(rstn), .ena_i(ena), .sw_rst_i(sw_rst),
        .clk_cnt_i(clk_cnt), .cmd_i(cmd), .cmd_valid_i(cmd_valid), .din_i(din),
        .lines_i(lines), .cmd_ack_o(cmd_ack), .busy_o(busy), .al_o(al),
        .dout_o(dout), .lines_oen_o(lines_oen)
    );

    bind i2c_bus_ctrl i2c_bus_ctrl_chk i_chk (
        .clk_i(clk_i), .rstn_i(rstn_i), .cmd_ack_i(cmd_ack_o),
        .al_i(al_o), .lines_oen_i(lines_oen_o)
    );

    // open drain, low wins
    assign lines.scl = lines_oen.scl & ~slave_scl_low;
    assign lines.sda = lines_oen.sda & ~slave_sda_low;

    // what a slave would latch on scl rise
    always @(posedge clk)
    begin
        scl_prev <= lines.scl;
        if (lines.scl && !scl_prev)
            sampled_sda <= lines.sda;
    end

    task automatic stop_with_failure();
        errors = errors + 1;
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic row_t make_row(input i2c_pkg::i2c_cmd_e c, input logic d,
                                      input logic [1:0] s, input logic a, input logic l,
                                      input logic cd, input logic ed, input logic b,
                                      input logic [1:0] ln);
        row_t r;
        r = '{cmd: c, din: d, slave: s, exp_ack: a, exp_al: l, chk_data: cd,
              exp_data: ed, exp_busy: b, exp_lines: ln};
        return r;
    endfunction

    task automatic run_row(input int idx);
        row_t r;
        int   cycles;
        logic got_ack;
        logic got_al;
        r = rows[idx];
        @(posedge clk);
        slave_scl_low <= (r.slave == SLV_STRETCH);
        slave_sda_low <= (r.slave == SLV_SDA_LOW);
        cmd           <= r.cmd;
        din           <= r.din;     // held for the whole command
        cmd_valid     <= 1'b1;
        @(posedge clk);
        cmd_valid     <= 1'b0;
        cmd           <= i2c_pkg::CMD_NONE;
        cycles  = 0;
        got_ack = 1'b0;
        got_al  = 1'b0;
        while (!got_ack && !got_al)
        begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles == STRETCH_CYC)
                slave_scl_low <= 1'b0;
            got_ack = cmd_ack;
            got_al  = al;
        end
        compare("cmd_ack_o", 32'(got_ack), 32'(r.exp_ack));
        compare("al_o", 32'(got_al), 32'(r.exp_al));
        if (r.chk_data)
        begin
            compare("dout_o", 32'(dout), 32'(r.exp_data));
            compare("sda at scl rise", 32'(sampled_sda), 32'(r.exp_data));
        end
        if (got_al)
        begin
            @(posedge clk);
            compare("lines_oen_o", 32'(lines_oen), 32'(2'b11));
        end
        if (r.cmd == i2c_pkg::CMD_WRITE && r.slave == SLV_NONE)
            base_cycles = cycles;
        if (r.slave == SLV_STRETCH && cycles <= base_cycles)
        begin
            $display("stretched write took %0d cycles, plain write took %0d", cycles, base_cycles);
            stop_with_failure();
        end
        slave_scl_low <= 1'b0;
        slave_sda_low <= 1'b0;
        repeat (SETTLE_CYC) @(posedge clk);
        compare("busy_o", 32'(busy), 32'(r.exp_busy));
        compare("bus lines", 32'(lines), 32'(r.exp_lines));
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: a command neither completed nor lost arbitration in time");
        stop_with_failure();
    end

    initial
    begin
        ena           = 1'b1;
        sw_rst        = 1'b0;
        clk_cnt       = 16'(CLK_CNT);
        cmd           = i2c_pkg::CMD_NONE;
        cmd_valid     = 1'b0;
        din           = 1'b0;
        slave_scl_low = 1'b0;
        slave_sda_low = 1'b0;
        scl_prev      = 1'b1;
        sampled_sda   = 1'b1;
        errors        = 0;
        base_cycles   = 0;
        // cmd, din, slave, ack, al, chk data, data, busy, lines
        rows[0] = make_row(i2c_pkg::CMD_START, 1'b0, SLV_NONE,    1, 0, 0, 1, 1, 2'b00);
        rows[1] = make_row(i2c_pkg::CMD_WRITE, 1'b1, SLV_NONE,    1, 0, 1, 1, 1, 2'b01);
        rows[2] = make_row(i2c_pkg::CMD_WRITE, 1'b0, SLV_NONE,    1, 0, 1, 0, 1, 2'b00);
        rows[3] = make_row(i2c_pkg::CMD_WRITE, 1'b1, SLV_NONE,    1, 0, 1, 1, 1, 2'b01);
        rows[4] = make_row(i2c_pkg::CMD_READ,  1'b0, SLV_SDA_LOW, 1, 0, 1, 0, 1, 2'b01);
        rows[5] = make_row(i2c_pkg::CMD_READ,  1'b0, SLV_NONE,    1, 0, 1, 1, 1, 2'b01);
        rows[6] = make_row(i2c_pkg::CMD_WRITE, 1'b0, SLV_STRETCH, 1, 0, 1, 0, 1, 2'b00);
        rows[7] = make_row(i2c_pkg::CMD_WRITE, 1'b1, SLV_SDA_LOW, 0, 1, 1, 0, 0, 2'b11);
        rows[8] = make_row(i2c_pkg::CMD_START, 1'b0, SLV_NONE,    1, 0, 0, 0, 1, 2'b00);
        rows[9] = make_row(i2c_pkg::CMD_STOP,  1'b0, SLV_NONE,    1, 0, 0, 0, 0, 2'b11);
        @(posedge rstn);
        @(posedge clk);
        compare("cmd_ack_o", 32'(cmd_ack), 32'(0));
        compare("busy_o", 32'(busy), 32'(0));
        compare("al_o", 32'(al), 32'(0));
        compare("lines_oen_o", 32'(lines_oen), 32'(2'b11));
        compare("dout_o", 32'(dout), 32'(1));
        for (int i = 0; i < NROWS; i++)
            run_row(i);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* i2c_bus_ctrl.f */
hw/i2c_pkg.sv
hw/i2c_bit_clock.sv
hw/i2c_line_filter.sv
hw/i2c_bit_sequencer.sv
hw/i2c_bus_ctrl.sv
testbench/tb_clk_gen.sv
testbench/i2c_bus_ctrl_chk.sv
testbench/i2c_bus_ctrl_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f i2c_bus_ctrl.f \
		--top-module i2c_bus_ctrl_tb -Mdir obj_dir -o sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
